//--- filelist.f
rv_pkg.sv
insn_decode.sv
reg_file.sv
alu_exec.sv
branch_unit.sv
commit_ctrl.sv
rv_core.sv
tb_rv_core.sv

//--- tb_rv_core.sv
`timescale 1ns/1ps

module tb_rv_core;

  localparam rv_pkg::addr_t RESET_PC = 32'h0000_0000;
  localparam rv_pkg::insn_t NOP_WORD = 32'h0000_0013;   // addi x0, x0, 0
  localparam rv_pkg::insn_t ECALL    = 32'h0000_0073;

  logic             clk;
  logic             rst;
  rv_pkg::addr_t    pc;
  rv_pkg::insn_t    insn;
  logic             rf_we;
  rv_pkg::reg_idx_t rf_waddr;
  rv_pkg::xlen_t    rf_wdata;
  logic             halt;

  // Program table, row i sits at RESET_PC + 4*i
  string            t_name [32];
  rv_pkg::insn_t    t_insn [32];
  logic             t_run  [32];   // Low when a taken branch jumps over the row
  logic             t_we   [32];
  rv_pkg::reg_idx_t t_rd   [32];
  rv_pkg::xlen_t    t_val  [32];
  int               n_rows;
  int               resume_at;
  rv_pkg::xlen_t    ref_x  [32];   // Reference register state
  logic [31:0]      rng = 32'h646b_c6d8;

  int cycles = 0;
  int errors = 0;
  int mark   = 0;
  int tests  = 0;
  int failed = 0;
  rv_pkg::addr_t halt_pc;

  rv_core #(.RESET_PC(RESET_PC)) dut (
    .clk      (clk),
    .rst      (rst),
    .pc       (pc),
    .insn     (insn),
    .rf_we    (rf_we),
    .rf_waddr (rf_waddr),
    .rf_wdata (rf_wdata),
    .halt     (halt)
  );

  always #10 clk = ~clk;

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [11:0] next_imm();
    rng = xorshift(rng);
    return rng[11:0];
  endfunction

  function automatic rv_pkg::xlen_t sext12(input logic [11:0] v);
    return {{20{v[11]}}, v};
  endfunction

  // Instruction encoders, field order as in the ISA manual
  function automatic rv_pkg::insn_t enc_i(input logic [11:0] imm, input rv_pkg::reg_idx_t rs1,
                                          input logic [2:0] f3, input rv_pkg::reg_idx_t rd,
                                          input rv_pkg::opcode_t op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic rv_pkg::insn_t enc_r(input logic [6:0] f7, input rv_pkg::reg_idx_t rs2,
                                          input rv_pkg::reg_idx_t rs1, input logic [2:0] f3,
                                          input rv_pkg::reg_idx_t rd);
    return {f7, rs2, rs1, f3, rd, rv_pkg::OP_REG};
  endfunction

  function automatic rv_pkg::insn_t enc_u(input logic [19:0] imm, input rv_pkg::reg_idx_t rd,
                                          input rv_pkg::opcode_t op);
    return {imm, rd, op};
  endfunction

  function automatic rv_pkg::insn_t enc_b(input logic [12:0] off, input rv_pkg::reg_idx_t rs2,
                                          input rv_pkg::reg_idx_t rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], rv_pkg::OP_BRANCH};
  endfunction

  function automatic rv_pkg::insn_t enc_j(input logic [20:0] off, input rv_pkg::reg_idx_t rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, rv_pkg::OP_JAL};
  endfunction

  function automatic rv_pkg::addr_t here();
    return RESET_PC + 32'(n_rows * 4);
  endfunction

  // Appends a row and advances the reference model if the row executes
  task automatic add_row(input string name, input rv_pkg::insn_t word, input logic we,
                         input rv_pkg::reg_idx_t rd, input rv_pkg::xlen_t val,
                         input rv_pkg::addr_t next_pc);
    t_name[n_rows] = name;
    t_insn[n_rows] = word;
    t_run[n_rows]  = (n_rows >= resume_at);
    t_we[n_rows]   = t_run[n_rows] && we && (rd != 5'd0);
    t_rd[n_rows]   = rd;
    t_val[n_rows]  = val;
    if (t_run[n_rows]) begin
      if (t_we[n_rows]) ref_x[rd] = val;
      resume_at = int'((next_pc - RESET_PC) >> 2);
    end
    n_rows++;
  endtask

  task automatic add_alu(input string name, input rv_pkg::insn_t word,
                         input rv_pkg::reg_idx_t rd, input rv_pkg::xlen_t val);
    add_row(name, word, 1'b1, rd, val, here() + 32'd4);
  endtask

  task automatic add_branch(input string name, input logic [2:0] f3, input rv_pkg::reg_idx_t rs1,
                            input rv_pkg::reg_idx_t rs2, input logic [12:0] off);
    rv_pkg::xlen_t a;
    rv_pkg::xlen_t b;
    logic          cond;
    a = ref_x[rs1];
    b = ref_x[rs2];
    case (f3)
      3'b000:  cond = (a == b);
      3'b001:  cond = (a != b);
      3'b100:  cond = ($signed(a) < $signed(b));
      3'b101:  cond = ($signed(a) >= $signed(b));
      3'b110:  cond = (a < b);
      default: cond = (a >= b);
    endcase
    add_row(name, enc_b(off, rs2, rs1, f3), 1'b0, 5'd0, '0,
            cond ? here() + sext12(off[12:1]) * 2 : here() + 32'd4);
  endtask

  task automatic build_program();
    logic [11:0] r;
    n_rows    = 0;
    resume_at = 0;
    for (int i = 0; i < 32; i++) begin
      ref_x[i] = '0;
    end
    add_alu("lui", enc_u(20'hFFFFF, 5'd1, rv_pkg::OP_LUI), 5'd1, 32'hFFFF_F000);
    add_alu("auipc", enc_u(20'h00001, 5'd2, rv_pkg::OP_AUIPC), 5'd2, here() + 32'h0000_1000);
    r = next_imm();
    add_alu("addi_rand", enc_i(r, 5'd0, 3'b000, 5'd3, rv_pkg::OP_IMM), 5'd3, sext12(r));
    r = next_imm();
    add_alu("ori_rand", enc_i(r, 5'd3, 3'b110, 5'd4, rv_pkg::OP_IMM), 5'd4, ref_x[3] | sext12(r));
    r = next_imm();
    add_alu("xori_rand", enc_i(r, 5'd4, 3'b100, 5'd5, rv_pkg::OP_IMM), 5'd5, ref_x[4] ^ sext12(r));
    add_alu("addi_neg", enc_i(12'hFF8, 5'd0, 3'b000, 5'd6, rv_pkg::OP_IMM), 5'd6, 32'hFFFF_FFF8);
    add_alu("slti_neg", enc_i(12'h001, 5'd6, 3'b010, 5'd7, rv_pkg::OP_IMM), 5'd7, 32'd1);  // -8 < 1
    add_alu("sltiu_neg", enc_i(12'h001, 5'd6, 3'b011, 5'd8, rv_pkg::OP_IMM), 5'd8, 32'd0);
    add_alu("slt_neg", enc_r(7'h00, 5'd6, 5'd0, 3'b010, 5'd9), 5'd9, 32'd0);    // 0 < -8 is false
    add_alu("sltu_neg", enc_r(7'h00, 5'd6, 5'd0, 3'b011, 5'd10), 5'd10, 32'd1);
    add_alu("srai_neg", enc_i({7'b0100000, 5'd2}, 5'd6, 3'b101, 5'd11, rv_pkg::OP_IMM), 5'd11,
            {{2{ref_x[6][31]}}, ref_x[6][31:2]});
    add_alu("srli_neg", enc_i(12'd2, 5'd6, 3'b101, 5'd12, rv_pkg::OP_IMM), 5'd12,
            {2'b00, ref_x[6][31:2]});
    add_alu("sub", enc_r(7'b0100000, 5'd6, 5'd3, 3'b000, 5'd13), 5'd13, ref_x[3] - ref_x[6]);
    add_alu("write_x0", enc_i(12'h123, 5'd0, 3'b000, 5'd0, rv_pkg::OP_IMM), 5'd0, 32'h123);
    add_alu("add_x0", enc_r(7'h00, 5'd4, 5'd0, 3'b000, 5'd14), 5'd14, ref_x[4]);
    add_branch("beq_taken", 3'b000, 5'd3, 5'd3, 13'd8);
    add_alu("skip_beq", enc_i(12'd1, 5'd0, 3'b000, 5'd15, rv_pkg::OP_IMM), 5'd15, 32'd1);
    add_branch("bne_fall", 3'b001, 5'd3, 5'd3, 13'd8);
    add_alu("after_bne", enc_i(12'd2, 5'd0, 3'b000, 5'd16, rv_pkg::OP_IMM), 5'd16, 32'd2);
    add_branch("blt_taken", 3'b100, 5'd6, 5'd0, 13'd8);
    add_alu("skip_blt", enc_i(12'd3, 5'd0, 3'b000, 5'd17, rv_pkg::OP_IMM), 5'd17, 32'd3);
    add_branch("bge_fall", 3'b101, 5'd6, 5'd0, 13'd8);
    add_alu("after_bge", enc_i(12'd4, 5'd0, 3'b000, 5'd17, rv_pkg::OP_IMM), 5'd17, 32'd4);
    add_row("jal", enc_j(21'd8, 5'd18), 1'b1, 5'd18, here() + 32'd4, here() + 32'd8);
    add_alu("skip_jal", enc_i(12'd5, 5'd0, 3'b000, 5'd19, rv_pkg::OP_IMM), 5'd19, 32'd5);
    // Odd sum on purpose, bit 0 must be dropped
    add_row("jalr", enc_i(12'd13, 5'd18, 3'b000, 5'd20, rv_pkg::OP_JALR), 1'b1, 5'd20,
            here() + 32'd4, (ref_x[18] + 32'd13) & ~32'd1);
    add_alu("skip_jalr", enc_i(12'd6, 5'd0, 3'b000, 5'd21, rv_pkg::OP_IMM), 5'd21, 32'd6);
    add_row("fence", 32'h0000_000F, 1'b0, 5'd0, '0, here() + 32'd4);
    add_row("ecall", ECALL, 1'b0, 5'd0, '0, here());
  endtask

  function automatic rv_pkg::insn_t fetch_word(input rv_pkg::addr_t a);
    int idx;
    idx = int'((a - RESET_PC) >> 2);
    return (idx < n_rows) ? t_insn[idx] : ECALL;
  endfunction

  // Synchronous instruction memory, answers one cycle after pc
  always @(posedge clk) begin
    insn <= fetch_word(pc);
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > 4 * n_rows + 40) begin
      $display("Timeout: core did not finish within %0d cycles", cycles - 1);
      $display("Checks failed");
      $finish;
    end
  end

  task automatic check_write(input logic we, input rv_pkg::reg_idx_t waddr,
                             input rv_pkg::xlen_t wdata, input logic exp_we,
                             input rv_pkg::reg_idx_t exp_rd, input rv_pkg::xlen_t exp_val);
    if (we !== exp_we) begin
      $display("MISMATCH rf_we: got %h, expected %h", we, exp_we);
      errors++;
    end else if (exp_we) begin
      if (waddr !== exp_rd) begin
        $display("MISMATCH rf_waddr: got %h, expected %h", waddr, exp_rd);
        errors++;
      end
      if (wdata !== exp_val) begin
        $display("MISMATCH rf_wdata: got %h, expected %h", wdata, exp_val);
        errors++;
      end
    end
  endtask

  task automatic check_pc(input rv_pkg::addr_t got, input rv_pkg::addr_t exp);
    if (got !== exp) begin
      $display("MISMATCH pc: got %h, expected %h", got, exp);
      errors++;
    end
  endtask

  task automatic check_halt(input logic got, input logic exp);
    if (got !== exp) begin
      $display("MISMATCH halt: got %h, expected %h", got, exp);
      errors++;
    end
  endtask

  task automatic finish_test(input string name);
    tests++;
    if (errors == mark) begin
      $display("PASS %s", name);
    end else begin
      failed++;
      $display("FAIL %s (%0d errors)", name, errors - mark);
    end
    mark = errors;
  endtask

  initial begin
    clk  = 1'b0;
    rst  = 1'b1;
    insn = NOP_WORD;
    build_program();
    repeat (16) @(posedge clk);
    rst <= 1'b0;

    @(negedge clk);   // First FETCH cycle
    check_pc(pc, RESET_PC);
    check_write(rf_we, rf_waddr, rf_wdata, 1'b0, 5'd0, '0);
    check_halt(halt, 1'b0);
    finish_test("reset");

    for (int i = 0; i < n_rows; i++) begin
      if (!t_run[i]) begin
        $display("SKIP %s (jumped over)", t_name[i]);
      end else begin
        @(posedge clk);   // End of FETCH
        check_pc(pc, RESET_PC + 32'(i * 4));
        @(posedge clk);   // End of EXEC
        check_write(rf_we, rf_waddr, rf_wdata, t_we[i], t_rd[i], t_val[i]);
        finish_test(t_name[i]);
      end
    end

    // Core sits on the ECALL
    halt_pc = RESET_PC + 32'((n_rows - 1) * 4);
    repeat (4) begin
      @(posedge clk);
      check_halt(halt, 1'b1);
      check_pc(pc, halt_pc);
      check_write(rf_we, rf_waddr, rf_wdata, 1'b0, 5'd0, '0);
    end
    finish_test("halt_hold");

    $display("Tests: %0d, failing: %0d, errors: %0d", tests, failed, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

//--- rv_core.sv
`timescale 1ns/1ps

module rv_core #(
  parameter rv_pkg::addr_t RESET_PC = '0
) (
  input  logic             clk,
  input  logic             rst,
  output rv_pkg::addr_t    pc,
  input  rv_pkg::insn_t    insn,
  output logic             rf_we,
  output rv_pkg::reg_idx_t rf_waddr,
  output rv_pkg::xlen_t    rf_wdata,
  output logic             halt
);

  // Decoded fields
  rv_pkg::reg_idx_t    rs1;
  rv_pkg::reg_idx_t    rs2;
  rv_pkg::reg_idx_t    rd;
  rv_pkg::xlen_t       imm;
  logic                use_imm;
  rv_pkg::alu_op_e     alu_op;
  rv_pkg::insn_class_e insn_class;
  logic [2:0]          funct3;

  // Operands and results
  rv_pkg::xlen_t       rs1_data;
  rv_pkg::xlen_t       rs2_data;
  rv_pkg::xlen_t       alu_result;
  logic                taken;
  rv_pkg::addr_t       target;

  insn_decode u_decode (
    .insn       (insn),
    .rs1        (rs1),
    .rs2        (rs2),
    .rd         (rd),
    .imm        (imm),
    .use_imm    (use_imm),
    .alu_op     (alu_op),
    .insn_class (insn_class),
    .funct3     (funct3)
  );

  reg_file u_regs (
    .clk      (clk),
    .rst      (rst),
    .rs1      (rs1),
    .rs2      (rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .we       (rf_we),
    .waddr    (rf_waddr),
    .wdata    (rf_wdata)
  );

  alu_exec u_alu (
    .alu_op     (alu_op),
    .use_imm    (use_imm),
    .rs1_data   (rs1_data),
    .rs2_data   (rs2_data),
    .imm        (imm),
    .pc         (pc),
    .alu_result (alu_result)
  );

  branch_unit u_branch (
    .insn_class (insn_class),
    .funct3     (funct3),
    .rs1_data   (rs1_data),
    .rs2_data   (rs2_data),
    .imm        (imm),
    .pc         (pc),
    .taken      (taken),
    .target     (target)
  );

  commit_ctrl #(
    .RESET_PC (RESET_PC)
  ) u_commit (
    .clk        (clk),
    .rst        (rst),
    .insn_class (insn_class),
    .rd         (rd),
    .alu_result (alu_result),
    .taken      (taken),
    .target     (target),
    .pc         (pc),
    .rf_we      (rf_we),
    .rf_waddr   (rf_waddr),
    .rf_wdata   (rf_wdata),
    .halt       (halt)
  );

endmodule

//--- commit_ctrl.sv
`timescale 1ns/1ps

module commit_ctrl #(
  parameter rv_pkg::addr_t RESET_PC = '0
) (
  input  logic                clk,
  input  logic                rst,
  input  rv_pkg::insn_class_e insn_class,
  input  rv_pkg::reg_idx_t    rd,
  input  rv_pkg::xlen_t       alu_result,
  input  logic                taken,
  input  rv_pkg::addr_t       target,
  output rv_pkg::addr_t       pc,
  output logic                rf_we,
  output rv_pkg::reg_idx_t    rf_waddr,
  output rv_pkg::xlen_t       rf_wdata,
  output logic                halt
);

  rv_pkg::core_state_e state;
  rv_pkg::core_state_e state_next;
  rv_pkg::addr_t       pc_next;
  logic                redirect;
  logic                writes_rd;

  assign redirect = (insn_class == rv_pkg::JAL) || (insn_class == rv_pkg::JALR) ||
                    (insn_class == rv_pkg::BRANCH && taken);
  assign pc_next  = redirect ? target : pc + 32'd4;

  assign writes_rd = insn_class inside {rv_pkg::ALU, rv_pkg::JAL, rv_pkg::JALR};

  // Two cycles per instruction, imem answers one cycle after pc
  always_comb begin
    case (state)
      rv_pkg::FETCH:  state_next = rv_pkg::EXEC;
      rv_pkg::EXEC:   state_next = (insn_class == rv_pkg::HALT) ? rv_pkg::HALTED : rv_pkg::FETCH;
      rv_pkg::HALTED: state_next = rv_pkg::HALTED;   // Only reset leaves
      default:        state_next = rv_pkg::FETCH;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= rv_pkg::FETCH;
      pc    <= RESET_PC;
    end else begin
      state <= state_next;
      if (state == rv_pkg::EXEC && insn_class != rv_pkg::HALT) begin
        pc <= pc_next;   // Halting leaves pc on the ECALL
      end
    end
  end

  assign rf_we    = (state == rv_pkg::EXEC) && writes_rd && (rd != '0);
  assign rf_waddr = rd;
  assign rf_wdata = alu_result;
  assign halt     = (state == rv_pkg::HALTED);

  // Each commit lands on a word boundary
  a_pc_aligned: assert property (
    @(posedge clk) disable iff (rst)
    (state == rv_pkg::EXEC) |=> (pc[1:0] == 2'b00)
  );

  // Halt is sticky and nothing more reaches the register file
  a_halt_quiet: assert property (
    @(posedge clk) disable iff (rst)
    halt |-> (!rf_we ##1 halt)
  );

endmodule

//--- branch_unit.sv
`timescale 1ns/1ps

module branch_unit (
  input  rv_pkg::insn_class_e insn_class,
  input  logic [2:0]          funct3,
  input  rv_pkg::xlen_t       rs1_data,
  input  rv_pkg::xlen_t       rs2_data,
  input  rv_pkg::xlen_t       imm,
  input  rv_pkg::addr_t       pc,
  output logic                taken,
  output rv_pkg::addr_t       target
);

  logic          eq;
  logic          lt;
  logic          ltu;
  logic          cond;
  rv_pkg::addr_t base;
  rv_pkg::addr_t sum;

  assign eq  = (rs1_data == rs2_data);
  assign lt  = ($signed(rs1_data) < $signed(rs2_data));
  assign ltu = (rs1_data < rs2_data);

  always_comb begin
    case (funct3)
      3'b000:  cond = eq;     // BEQ
      3'b001:  cond = !eq;    // BNE
      3'b100:  cond = lt;     // BLT
      3'b101:  cond = !lt;    // BGE
      3'b110:  cond = ltu;    // BLTU
      3'b111:  cond = !ltu;   // BGEU
      default: cond = 1'b0;
    endcase
  end

  assign taken = (insn_class == rv_pkg::BRANCH) && cond;

  // Register-relative for JALR, PC-relative otherwise
  assign base = (insn_class == rv_pkg::JALR) ? rs1_data : pc;
  assign sum  = base + imm;

  assign target = (insn_class == rv_pkg::JALR) ? {sum[31:1], 1'b0} : sum;

endmodule

//--- alu_exec.sv
`timescale 1ns/1ps

module alu_exec (
  input  rv_pkg::alu_op_e alu_op,
  input  logic            use_imm,
  input  rv_pkg::xlen_t   rs1_data,
  input  rv_pkg::xlen_t   rs2_data,
  input  rv_pkg::xlen_t   imm,
  input  rv_pkg::addr_t   pc,
  output rv_pkg::xlen_t   alu_result
);

  rv_pkg::xlen_t op_b;
  logic [4:0]    shamt;
  rv_pkg::xlen_t pc_offset;

  assign op_b  = use_imm ? imm : rs2_data;
  assign shamt = op_b[4:0];   // Only low 5 bits count for RV32

  // AUIPC carries imm, JAL/JALR link to the next word
  assign pc_offset = use_imm ? imm : rv_pkg::xlen_t'(4);

  always_comb begin
    case (alu_op)
      rv_pkg::ADD:    alu_result = rs1_data + op_b;
      rv_pkg::SUB:    alu_result = rs1_data - op_b;
      rv_pkg::SLL:    alu_result = rs1_data << shamt;
      rv_pkg::SLT: begin
        alu_result = {{(rv_pkg::XLEN-1){1'b0}}, $signed(rs1_data) < $signed(op_b)};
      end
      rv_pkg::SLTU: begin
        alu_result = {{(rv_pkg::XLEN-1){1'b0}}, rs1_data < op_b};
      end
      rv_pkg::XOR:    alu_result = rs1_data ^ op_b;
      rv_pkg::SRL:    alu_result = rs1_data >> shamt;
      rv_pkg::SRA:    alu_result = rv_pkg::xlen_t'($signed(rs1_data) >>> shamt);
      rv_pkg::OR:     alu_result = rs1_data | op_b;
      rv_pkg::AND:    alu_result = rs1_data & op_b;
      rv_pkg::PASS_B: alu_result = op_b;   // LUI, imm already shifted
      rv_pkg::LINK:   alu_result = pc + pc_offset;
      default:        alu_result = '0;
    endcase
  end

endmodule

//--- reg_file.sv
`timescale 1ns/1ps

module reg_file (
  input  logic             clk,
  input  logic             rst,
  input  rv_pkg::reg_idx_t rs1,
  input  rv_pkg::reg_idx_t rs2,
  output rv_pkg::xlen_t    rs1_data,
  output rv_pkg::xlen_t    rs2_data,
  input  logic             we,
  input  rv_pkg::reg_idx_t waddr,
  input  rv_pkg::xlen_t    wdata
);

  rv_pkg::xlen_t regs [0:31];   // x0 is cleared on reset and never written

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && waddr != '0) begin
      regs[waddr] <= wdata;
    end
  end

  // Combinational read with new data visible the cycle after the write
  assign rs1_data = regs[rs1];
  assign rs2_data = regs[rs2];

  // x0 stays zero even after a write aimed at it
  a_x0_reads_zero: assert property (
    @(posedge clk) disable iff (rst)
    (rs1 == '0) |-> (rs1_data == '0)
  );

endmodule

//--- insn_decode.sv
`timescale 1ns/1ps

module insn_decode (
  input  rv_pkg::insn_t       insn,
  output rv_pkg::reg_idx_t    rs1,
  output rv_pkg::reg_idx_t    rs2,
  output rv_pkg::reg_idx_t    rd,
  output rv_pkg::xlen_t       imm,
  output logic                use_imm,
  output rv_pkg::alu_op_e     alu_op,
  output rv_pkg::insn_class_e insn_class,
  output logic [2:0]          funct3
);

  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000;   // SUB, SRA, SRAI

  rv_pkg::opcode_t opcode;
  logic [6:0]      funct7;
  rv_pkg::xlen_t   imm_i;
  rv_pkg::xlen_t   imm_u;
  rv_pkg::xlen_t   imm_b;
  rv_pkg::xlen_t   imm_j;
  rv_pkg::alu_op_e arith_op;   // Shared by OP_IMM and OP_REG
  logic            arith_ok;

  assign opcode = insn[6:0];
  assign rd     = insn[11:7];
  assign funct3 = insn[14:12];
  assign rs1    = insn[19:15];
  assign rs2    = insn[24:20];
  assign funct7 = insn[31:25];

  // Sign-extended immediates
  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  assign imm_u = {insn[31:12], 12'b0};
  assign imm_b = {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_j = {{12{insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};

  // funct3 to ALU function, funct7 only matters for ADD/SUB and the shifts
  always_comb begin
    arith_op = rv_pkg::ADD;
    case (funct3)
      3'b000: arith_op = (opcode == rv_pkg::OP_REG && funct7 == F7_ALT) ?
                         rv_pkg::SUB : rv_pkg::ADD;
      3'b001: arith_op = rv_pkg::SLL;
      3'b010: arith_op = rv_pkg::SLT;
      3'b011: arith_op = rv_pkg::SLTU;
      3'b100: arith_op = rv_pkg::XOR;
      3'b101: arith_op = (funct7 == F7_ALT) ? rv_pkg::SRA : rv_pkg::SRL;
      3'b110: arith_op = rv_pkg::OR;
      default: arith_op = rv_pkg::AND;
    endcase

    if (opcode == rv_pkg::OP_REG) begin
      arith_ok = (funct7 == F7_BASE) ||
                 (funct7 == F7_ALT && (funct3 == 3'b000 || funct3 == 3'b101));
    end else if (funct3 == 3'b001) begin
      arith_ok = (funct7 == F7_BASE);   // SLLI
    end else if (funct3 == 3'b101) begin
      arith_ok = (funct7 == F7_BASE) || (funct7 == F7_ALT);
    end else begin
      arith_ok = 1'b1;   // Upper bits are immediate
    end
  end

  always_comb begin
    imm        = imm_i;
    use_imm    = 1'b0;
    alu_op     = rv_pkg::ADD;
    insn_class = rv_pkg::HALT;   // Anything not matched below stops the core
    case (opcode)
      rv_pkg::OP_LUI: begin
        imm        = imm_u;
        use_imm    = 1'b1;
        alu_op     = rv_pkg::PASS_B;
        insn_class = rv_pkg::ALU;
      end
      rv_pkg::OP_AUIPC: begin
        imm        = imm_u;
        use_imm    = 1'b1;   // LINK adds imm instead of 4
        alu_op     = rv_pkg::LINK;
        insn_class = rv_pkg::ALU;
      end
      rv_pkg::OP_JAL: begin
        imm        = imm_j;
        alu_op     = rv_pkg::LINK;
        insn_class = rv_pkg::JAL;
      end
      rv_pkg::OP_JALR: begin
        alu_op = rv_pkg::LINK;
        if (funct3 == 3'b000) begin
          insn_class = rv_pkg::JALR;
        end
      end
      rv_pkg::OP_BRANCH: begin
        imm = imm_b;
        if (funct3[2:1] != 2'b01) begin   // 010 and 011 are unused
          insn_class = rv_pkg::BRANCH;
        end
      end
      rv_pkg::OP_IMM: begin
        use_imm = 1'b1;
        alu_op  = arith_op;
        if (arith_ok) begin
          insn_class = rv_pkg::ALU;
        end
      end
      rv_pkg::OP_REG: begin
        alu_op = arith_op;
        if (arith_ok) begin
          insn_class = rv_pkg::ALU;
        end
      end
      rv_pkg::OP_FENCE: begin
        if (funct3 == 3'b000) begin
          insn_class = rv_pkg::NOP;   // Single hart, no memory to order
        end
      end
      rv_pkg::OP_SYSTEM: insn_class = rv_pkg::HALT;   // ECALL and the rest
      default: insn_class = rv_pkg::HALT;
    endcase
  end

endmodule

//--- rv_pkg.sv
package rv_pkg;

  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] xlen_t;     // Register values, operands, results
  typedef logic [31:0]     addr_t;     // Instruction address
  typedef logic [31:0]     insn_t;
  typedef logic [4:0]      reg_idx_t;
  typedef logic [6:0]      opcode_t;

  // RV32I base opcodes
  localparam opcode_t OP_LUI    = 7'b0110111;
  localparam opcode_t OP_AUIPC  = 7'b0010111;
  localparam opcode_t OP_JAL    = 7'b1101111;
  localparam opcode_t OP_JALR   = 7'b1100111;
  localparam opcode_t OP_BRANCH = 7'b1100011;
  localparam opcode_t OP_IMM    = 7'b0010011;
  localparam opcode_t OP_REG    = 7'b0110011;
  localparam opcode_t OP_FENCE  = 7'b0001111;
  localparam opcode_t OP_SYSTEM = 7'b1110011;   // ECALL lives here

  // ALU function
  typedef enum logic [3:0] {
    ADD,
    SUB,
    SLL,
    SLT,
    SLTU,
    XOR,
    SRL,
    SRA,
    OR,
    AND,
    PASS_B,   // LUI
    LINK      // PC relative, pc + 4 or pc + imm
  } alu_op_e;

  // What the commit stage does with the instruction
  typedef enum logic [2:0] {
    ALU,
    BRANCH,
    JAL,
    JALR,
    NOP,
    HALT
  } insn_class_e;

  typedef enum logic [1:0] {
    FETCH,
    EXEC,
    HALTED
  } core_state_e;

endpackage
